// ==== include/rv32_defs.svh ====
//////////////////////////////
// rv32 core definitions
// widths, opcodes, function codes and reset pc
//////////////////////////////
`ifndef RV32_DEFS_SVH
`define RV32_DEFS_SVH

`define RV32_XLEN     32
`define RV32_REG_AW   5
`define RV32_BE_W     4
`define RV32_RESET_PC 32'h0000_0000

// major opcodes
`define RV32_OPC_LUI    7'h37
`define RV32_OPC_OP_IMM 7'h13
`define RV32_OPC_OP     7'h33
`define RV32_OPC_LOAD   7'h03
`define RV32_OPC_STORE  7'h23
`define RV32_OPC_BRANCH 7'h63
`define RV32_OPC_JAL    7'h6f

// funct3 codes
`define RV32_F3_ADD 3'b000
`define RV32_F3_XOR 3'b100
`define RV32_F3_OR  3'b110
`define RV32_F3_AND 3'b111
`define RV32_F3_LW  3'b010
`define RV32_F3_SW  3'b010
`define RV32_F3_SB  3'b000
`define RV32_F3_BEQ 3'b000
`define RV32_F3_BNE 3'b001

// funct7 codes
`define RV32_F7_ADD 7'b0000000
`define RV32_F7_SUB 7'b0100000

`endif

// ==== logic/rv32_pkg.sv ====
//////////////////////////////
// rv32 core types
// shared vectors, enums and the bus request
//////////////////////////////
`include "rv32_defs.svh"

package rv32_pkg;

	//////////////////////////////
	// vectors

	typedef logic [`RV32_XLEN-1:0]   word_t;
	typedef logic [`RV32_REG_AW-1:0] reg_idx_t;
	typedef logic [`RV32_BE_W-1:0]   be_t;

	//////////////////////////////
	// enums

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS_B
	} alu_op_e;

	// instruction sequencing
	typedef enum logic [1:0] {
		WAIT_ENABLE,
		FETCH,
		EXECUTE,
		MEM_WAIT
	} exec_state_e;

	//////////////////////////////
	// bus request

	// request fields of the memory port, 69 bits
	typedef struct packed {
		word_t addr;
		logic  we;
		be_t   be;
		word_t wdata;
	} bus_req_t;

endpackage

// ==== logic/rv32_regfile.sv ====
//////////////////////////////
// rv32 register file
// x1 to x31, two read ports and one write port
//////////////////////////////
`timescale 1ns/100ps

module rv32_regfile (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  rv32_pkg::reg_idx_t raddr_a_i,
	input  rv32_pkg::reg_idx_t raddr_b_i,
	output rv32_pkg::word_t    rdata_a_o,
	output rv32_pkg::word_t    rdata_b_o,
	input  logic               we_i,
	input  rv32_pkg::reg_idx_t waddr_i,
	input  rv32_pkg::word_t    wdata_i
);
	import rv32_pkg::*;

	// x0 has no storage
	word_t regs_q [1:31];

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			for (int i = 1; i < 32; i++) begin
				regs_q[i] <= '0;
			end
		end else if (we_i && waddr_i != '0) begin
			regs_q[waddr_i] <= wdata_i;
		end
	end

	assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
	assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

	// a write aimed at x0 leaves the register read on port a unchanged
	assert property (@(posedge clk_i) disable iff (!rst_ni)
		we_i && waddr_i == '0 |=> raddr_a_i != $past(raddr_a_i) || $stable(rdata_a_o));

endmodule

// ==== logic/rv32_fetch.sv ====
//////////////////////////////
// rv32 fetch unit
// holds the pc and reads one instruction at a time
//////////////////////////////
`timescale 1ns/100ps
`include "rv32_defs.svh"

module rv32_fetch (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  logic               start_i,
	input  logic               redirect_i,
	input  rv32_pkg::word_t    target_i,
	output logic               req_o,
	output rv32_pkg::bus_req_t req_o_data_o,
	input  logic               gnt_i,
	input  logic               rvalid_i,
	input  rv32_pkg::word_t    rdata_i,
	output logic               instr_valid_o,
	output rv32_pkg::word_t    instr_o,
	output rv32_pkg::word_t    pc_o
);
	import rv32_pkg::*;

	// pc_q is the next sequential fetch address
	word_t pc_q;
	word_t addr_q;
	word_t instr_q;
	logic  req_q;
	logic  busy_q;
	logic  valid_q;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			pc_q    <= `RV32_RESET_PC;
			req_q   <= 1'b0;
			busy_q  <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= rvalid_i;
			if (rvalid_i) begin
				busy_q <= 1'b0;
				pc_q   <= addr_q + 32'd4;
			end
			if (start_i) begin
				req_q  <= 1'b1;
				busy_q <= 1'b1;
			end else if (gnt_i) begin
				req_q <= 1'b0;
			end
		end
	end

	// address and instruction words
	always_ff @(posedge clk_i) begin
		if (start_i) begin
			addr_q <= redirect_i ? target_i : pc_q;
		end
		if (rvalid_i) begin
			instr_q <= rdata_i;
		end
	end

	assign req_o        = req_q;
	assign req_o_data_o = '{addr: addr_q, we: 1'b0, be: '1, wdata: '0};

	assign instr_valid_o = valid_q;
	assign instr_o       = instr_q;
	assign pc_o          = addr_q;

	//////////////////////////////
	// checks

	// decode/execute only starts a fetch once the previous one returned
	assert property (@(posedge clk_i) disable iff (!rst_ni) start_i |-> !busy_q);

endmodule

// ==== logic/rv32_lsu.sv ====
//////////////////////////////
// rv32 load/store unit
// one data transaction at a time on the shared port
//////////////////////////////
`timescale 1ns/100ps

module rv32_lsu (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  logic               start_i,
	input  rv32_pkg::bus_req_t op_i,
	output logic               req_o,
	output rv32_pkg::bus_req_t req_data_o,
	input  logic               gnt_i,
	input  logic               rvalid_i,
	input  rv32_pkg::word_t    rdata_i,
	output logic               done_o,
	output rv32_pkg::word_t    load_data_o
);
	import rv32_pkg::*;

	bus_req_t op_q;
	word_t    load_q;
	logic     req_q;
	logic     done_q;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			req_q  <= 1'b0;
			done_q <= 1'b0;
		end else begin
			done_q <= rvalid_i;
			if (start_i) begin
				req_q <= 1'b1;
			end else if (gnt_i) begin
				req_q <= 1'b0;
			end
		end
	end

	// request fields from decode, read data from the port
	always_ff @(posedge clk_i) begin
		if (start_i) begin
			op_q <= op_i;
		end
		if (rvalid_i) begin
			load_q <= rdata_i;
		end
	end

	assign req_o       = req_q;
	assign req_data_o  = op_q;
	assign done_o      = done_q;
	assign load_data_o = load_q;

	//////////////////////////////
	// checks

	// a waiting request keeps its fields until the arbiter grants it
	assert property (@(posedge clk_i) disable iff (!rst_ni)
		req_o && !gnt_i |=> req_o && $stable(req_data_o));

endmodule

// ==== logic/rv32_bus_arbiter.sv ====
//////////////////////////////
// rv32 bus arbiter
// shares the memory port between fetch and load/store
//////////////////////////////
`timescale 1ns/100ps

module rv32_bus_arbiter (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  logic               fetch_req_i,
	input  rv32_pkg::bus_req_t fetch_data_i,
	input  logic               lsu_req_i,
	input  rv32_pkg::bus_req_t lsu_data_i,
	output logic               fetch_gnt_o,
	output logic               lsu_gnt_o,
	output logic               fetch_rvalid_o,
	output logic               lsu_rvalid_o,
	output logic               bus_req_o,
	output rv32_pkg::bus_req_t bus_o,
	input  logic               bus_gnt_i,
	input  logic               bus_rvalid_i
);
	import rv32_pkg::*;

	// one transaction in flight and who issued it
	logic busy_q;
	logic owner_lsu_q;
	logic lsu_sel;

	// load/store wins over fetch
	assign lsu_sel = lsu_req_i;

	assign bus_req_o = !busy_q && (lsu_req_i || fetch_req_i);
	assign bus_o     = lsu_sel ? lsu_data_i : fetch_data_i;

	assign lsu_gnt_o   = bus_gnt_i && !busy_q && lsu_sel;
	assign fetch_gnt_o = bus_gnt_i && !busy_q && !lsu_sel && fetch_req_i;

	assign lsu_rvalid_o   = bus_rvalid_i && busy_q && owner_lsu_q;
	assign fetch_rvalid_o = bus_rvalid_i && busy_q && !owner_lsu_q;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			busy_q      <= 1'b0;
			owner_lsu_q <= 1'b0;
		end else if (bus_req_o && bus_gnt_i) begin
			busy_q      <= 1'b1;
			owner_lsu_q <= lsu_sel;
		end else if (bus_rvalid_i) begin
			busy_q <= 1'b0;
		end
	end

	//////////////////////////////
	// checks

	assert property (@(posedge clk_i) disable iff (!rst_ni)
		!(fetch_gnt_o && lsu_gnt_o));

	// memory answers only a granted transaction
	assert property (@(posedge clk_i) disable iff (!rst_ni)
		bus_rvalid_i |-> busy_q);

endmodule

// ==== logic/rv32_decode_exec.sv ====
//////////////////////////////
// rv32 decode and execute
// decoder, alu, branches and the sequencing FSM
//////////////////////////////
`timescale 1ns/100ps
`include "rv32_defs.svh"

module rv32_decode_exec (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  logic               fetch_enable_i,
	input  logic               instr_valid_i,
	input  rv32_pkg::word_t    instr_i,
	input  rv32_pkg::word_t    pc_i,
	output logic               fetch_start_o,
	output logic               redirect_o,
	output rv32_pkg::word_t    target_o,
	output rv32_pkg::reg_idx_t rs1_o,
	output rv32_pkg::reg_idx_t rs2_o,
	input  rv32_pkg::word_t    rs1_data_i,
	input  rv32_pkg::word_t    rs2_data_i,
	output logic               we_o,
	output rv32_pkg::reg_idx_t rd_o,
	output rv32_pkg::word_t    wdata_o,
	output logic               lsu_start_o,
	output rv32_pkg::bus_req_t lsu_op_o,
	output rv32_pkg::reg_idx_t lsu_rd_o,
	input  logic               lsu_done_i,
	input  rv32_pkg::word_t    load_data_i
);
	import rv32_pkg::*;

	exec_state_e state_q;
	exec_state_e state_d;
	reg_idx_t    ld_rd_q;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic is_lui, is_op, is_op_imm, is_load, is_store, is_branch, is_jal;
	word_t imm_i, imm_s, imm_b, imm_u, imm_j;
	word_t mem_addr;
	alu_op_e alu_op;
	word_t alu_b;
	word_t alu_res;
	logic branch_taken;

	//////////////////////////////
	// decode

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];
	assign rs1_o  = instr_i[19:15];
	assign rs2_o  = instr_i[24:20];

	assign is_lui    = opcode == `RV32_OPC_LUI;
	assign is_op     = opcode == `RV32_OPC_OP;
	assign is_op_imm = opcode == `RV32_OPC_OP_IMM;
	assign is_load   = opcode == `RV32_OPC_LOAD;
	assign is_store  = opcode == `RV32_OPC_STORE;
	assign is_branch = opcode == `RV32_OPC_BRANCH;
	assign is_jal    = opcode == `RV32_OPC_JAL;

	assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
		instr_i[11:8], 1'b0};
	assign imm_u = {instr_i[31:12], 12'b0};
	assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
		instr_i[30:21], 1'b0};

	//////////////////////////////
	// alu and branch

	always_comb begin
		alu_op = ALU_ADD;
		alu_b  = is_op ? rs2_data_i : imm_i;
		if (is_lui) begin
			alu_op = ALU_PASS_B;
			alu_b  = imm_u;
		end else if (is_op || is_op_imm) begin
			case (funct3)
				`RV32_F3_XOR: alu_op = ALU_XOR;
				`RV32_F3_OR:  alu_op = ALU_OR;
				`RV32_F3_AND: alu_op = ALU_AND;
				`RV32_F3_ADD: alu_op = (is_op && funct7 == `RV32_F7_SUB) ? ALU_SUB : ALU_ADD;
				default:      alu_op = ALU_ADD;
			endcase
		end
	end

	always_comb begin
		case (alu_op)
			ALU_SUB:    alu_res = rs1_data_i - alu_b;
			ALU_AND:    alu_res = rs1_data_i & alu_b;
			ALU_OR:     alu_res = rs1_data_i | alu_b;
			ALU_XOR:    alu_res = rs1_data_i ^ alu_b;
			ALU_PASS_B: alu_res = alu_b;
			default:    alu_res = rs1_data_i + alu_b;
		endcase
	end

	always_comb begin
		case (funct3)
			`RV32_F3_BEQ: branch_taken = rs1_data_i == rs2_data_i;
			`RV32_F3_BNE: branch_taken = rs1_data_i != rs2_data_i;
			default:      branch_taken = 1'b0;
		endcase
	end

	assign target_o = pc_i + (is_jal ? imm_j : imm_b);

	//////////////////////////////
	// memory request

	assign mem_addr = rs1_data_i + (is_store ? imm_s : imm_i);

	// word aligned address, byte stores replicate the byte over all lanes
	always_comb begin
		lsu_op_o.addr = {mem_addr[31:2], 2'b00};
		lsu_op_o.we   = is_store;
		if (is_store && funct3 == `RV32_F3_SB) begin
			lsu_op_o.be    = be_t'(1) << mem_addr[1:0];
			lsu_op_o.wdata = {4{rs2_data_i[7:0]}};
		end else begin
			lsu_op_o.be    = '1;
			lsu_op_o.wdata = is_store ? rs2_data_i : '0;
		end
	end

	// stores keep x0 as destination so nothing is written back
	always_ff @(posedge clk_i) begin
		if (lsu_start_o) begin
			ld_rd_q <= is_load ? instr_i[11:7] : '0;
		end
	end

	assign lsu_rd_o = ld_rd_q;

	//////////////////////////////
	// sequencing

	always_comb begin
		state_d       = state_q;
		fetch_start_o = 1'b0;
		redirect_o    = 1'b0;
		we_o          = 1'b0;
		lsu_start_o   = 1'b0;
		case (state_q)
			WAIT_ENABLE: begin
				if (fetch_enable_i) begin
					fetch_start_o = 1'b1;
					state_d       = FETCH;
				end
			end
			FETCH: begin
				if (instr_valid_i) begin
					state_d = EXECUTE;
				end
			end
			EXECUTE: begin
				if (is_load || is_store) begin
					lsu_start_o = 1'b1;
					state_d     = MEM_WAIT;
				end else begin
					we_o          = is_lui || is_op || is_op_imm || is_jal;
					fetch_start_o = 1'b1;
					redirect_o    = is_jal || (is_branch && branch_taken);
					state_d       = FETCH;
				end
			end
			MEM_WAIT: begin
				if (lsu_done_i) begin
					we_o          = ld_rd_q != '0;
					fetch_start_o = 1'b1;
					state_d       = FETCH;
				end
			end
			default: state_d = WAIT_ENABLE;
		endcase
	end

	assign rd_o    = (state_q == MEM_WAIT) ? ld_rd_q : instr_i[11:7];
	assign wdata_o = (state_q == MEM_WAIT) ? load_data_i : (is_jal ? pc_i + 32'd4 : alu_res);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= WAIT_ENABLE;
		end else begin
			state_q <= state_d;
		end
	end

endmodule

// ==== logic/rv32_core.sv ====
//////////////////////////////
// rv32 core top level
// fetch, execute, registers and load/store on one memory port
//////////////////////////////
`timescale 1ns/100ps

module rv32_core (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  logic               fetch_enable_i,
	output logic               bus_req_o,
	output rv32_pkg::bus_req_t bus_o,
	input  logic               bus_gnt_i,
	input  logic               bus_rvalid_i,
	input  rv32_pkg::word_t    bus_rdata_i
);
	import rv32_pkg::*;

	logic     fetch_start;
	logic     fetch_redirect;
	word_t    fetch_target;
	logic     fetch_req;
	bus_req_t fetch_data;
	logic     fetch_gnt;
	logic     fetch_rvalid;
	logic     instr_valid;
	word_t    instr;
	word_t    instr_pc;

	logic     lsu_start;
	bus_req_t lsu_op;
	logic     lsu_req;
	bus_req_t lsu_data;
	logic     lsu_gnt;
	logic     lsu_rvalid;
	logic     lsu_done;
	word_t    load_data;

	reg_idx_t rs1;
	reg_idx_t rs2;
	word_t    rs1_data;
	word_t    rs2_data;
	logic     rd_we;
	reg_idx_t rd;
	word_t    rd_wdata;

	rv32_fetch fetch_i (
		.clk_i         (clk_i),
		.rst_ni        (rst_ni),
		.start_i       (fetch_start),
		.redirect_i    (fetch_redirect),
		.target_i      (fetch_target),
		.req_o         (fetch_req),
		.req_o_data_o  (fetch_data),
		.gnt_i         (fetch_gnt),
		.rvalid_i      (fetch_rvalid),
		.rdata_i       (bus_rdata_i),
		.instr_valid_o (instr_valid),
		.instr_o       (instr),
		.pc_o          (instr_pc)
	);

	// the load destination is tracked inside decode/execute
	rv32_decode_exec decode_exec_i (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.fetch_enable_i (fetch_enable_i),
		.instr_valid_i  (instr_valid),
		.instr_i        (instr),
		.pc_i           (instr_pc),
		.fetch_start_o  (fetch_start),
		.redirect_o     (fetch_redirect),
		.target_o       (fetch_target),
		.rs1_o          (rs1),
		.rs2_o          (rs2),
		.rs1_data_i     (rs1_data),
		.rs2_data_i     (rs2_data),
		.we_o           (rd_we),
		.rd_o           (rd),
		.wdata_o        (rd_wdata),
		.lsu_start_o    (lsu_start),
		.lsu_op_o       (lsu_op),
		.lsu_rd_o       (),
		.lsu_done_i     (lsu_done),
		.load_data_i    (load_data)
	);

	rv32_regfile regfile_i (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.raddr_a_i (rs1),
		.raddr_b_i (rs2),
		.rdata_a_o (rs1_data),
		.rdata_b_o (rs2_data),
		.we_i      (rd_we),
		.waddr_i   (rd),
		.wdata_i   (rd_wdata)
	);

	rv32_lsu lsu_i (
		.clk_i       (clk_i),
		.rst_ni      (rst_ni),
		.start_i     (lsu_start),
		.op_i        (lsu_op),
		.req_o       (lsu_req),
		.req_data_o  (lsu_data),
		.gnt_i       (lsu_gnt),
		.rvalid_i    (lsu_rvalid),
		.rdata_i     (bus_rdata_i),
		.done_o      (lsu_done),
		.load_data_o (load_data)
	);

	rv32_bus_arbiter arbiter_i (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.fetch_req_i    (fetch_req),
		.fetch_data_i   (fetch_data),
		.lsu_req_i      (lsu_req),
		.lsu_data_i     (lsu_data),
		.fetch_gnt_o    (fetch_gnt),
		.lsu_gnt_o      (lsu_gnt),
		.fetch_rvalid_o (fetch_rvalid),
		.lsu_rvalid_o   (lsu_rvalid),
		.bus_req_o      (bus_req_o),
		.bus_o          (bus_o),
		.bus_gnt_i      (bus_gnt_i),
		.bus_rvalid_i   (bus_rvalid_i)
	);

endmodule

// ==== tb/rv32_core_checker.sv ====
//////////////////////////////
// rv32 core checker
// instruction set model compared with every bus grant
//////////////////////////////
`timescale 1ns/100ps
`include "rv32_defs.svh"

module rv32_core_checker (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  logic               fetch_enable_i,
	input  logic               bus_req_i,
	input  rv32_pkg::bus_req_t bus_i,
	input  logic               bus_gnt_i,
	input  logic               bus_rvalid_i,
	input  rv32_pkg::word_t    done_addr_i,
	output logic               done_o,
	output int                 fetch_errs_o,
	output int                 data_errs_o,
	output int                 proto_errs_o
);
	import rv32_pkg::*;

	// memory image loaded by the testbench, word index from address bits 13:2
	word_t    ref_mem [0:4095];
	word_t    regs [0:31];
	word_t    pc;
	logic     data_next;
	bus_req_t data_exp;
	logic     enable_seen;
	logic     outstanding;
	logic     waiting;
	bus_req_t held;

	function automatic bit differs(input string name, input word_t exp, input word_t got);
		if (got !== exp) begin
			$display("** Error at %0t: %s expected %h got %h", $time, name, exp, got);
			return 1'b1;
		end
		return 1'b0;
	endfunction

	function automatic word_t sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic word_t op_result(input word_t ins, input word_t a, input word_t b);
		case (ins[14:12])
			`RV32_F3_AND: return a & b;
			`RV32_F3_OR:  return a | b;
			`RV32_F3_XOR: return a ^ b;
			default:      return (ins[31:25] == `RV32_F7_SUB) ? a - b : a + b;
		endcase
	endfunction

	task automatic write_reg(input reg_idx_t rd, input word_t v);
		if (rd != 0) begin
			regs[rd] = v;
		end
	endtask

	//////////////////////////////
	// instruction set model

	task automatic execute_at_pc();
		word_t    ins;
		word_t    a;
		word_t    b;
		word_t    addr;
		reg_idx_t rd;
		int       k;
		ins  = ref_mem[pc[13:2]];
		rd   = ins[11:7];
		a    = regs[ins[19:15]];
		b    = regs[ins[24:20]];
		addr = '0;
		case (ins[6:0])
			`RV32_OPC_LUI: begin
				write_reg(rd, {ins[31:12], 12'h000});
				pc = pc + 4;
			end
			`RV32_OPC_OP_IMM: begin
				write_reg(rd, a + sext12(ins[31:20]));
				pc = pc + 4;
			end
			`RV32_OPC_OP: begin
				write_reg(rd, op_result(ins, a, b));
				pc = pc + 4;
			end
			`RV32_OPC_LOAD: begin
				addr      = a + sext12(ins[31:20]);
				data_exp  = '{addr: addr, we: 1'b0, be: 4'hf, wdata: '0};
				data_next = 1'b1;
				write_reg(rd, ref_mem[addr[13:2]]);
				pc = pc + 4;
			end
			`RV32_OPC_STORE: begin
				addr = a + sext12({ins[31:25], ins[11:7]});
				// a byte store goes out on the aligned word with one lane enabled
				if (ins[14:12] == `RV32_F3_SB) begin
					data_exp = '{addr: {addr[31:2], 2'b00}, we: 1'b1,
						be: 4'b0001 << addr[1:0], wdata: {4{b[7:0]}}};
				end else begin
					data_exp = '{addr: addr, we: 1'b1, be: 4'hf, wdata: b};
				end
				for (k = 0; k < 4; k++) begin
					if (data_exp.be[k]) begin
						ref_mem[addr[13:2]][8*k +: 8] = data_exp.wdata[8*k +: 8];
					end
				end
				data_next = 1'b1;
				pc = pc + 4;
			end
			`RV32_OPC_BRANCH: begin
				if ((ins[14:12] == `RV32_F3_BEQ) ? (a == b) : (a != b)) begin
					pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
				end else begin
					pc = pc + 4;
				end
			end
			`RV32_OPC_JAL: begin
				write_reg(rd, pc + 4);
				pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			end
			default: begin
				$display("model met unknown instruction %h at pc %h", ins, pc);
				fetch_errs_o++;
				pc = pc + 4;
			end
		endcase
	endtask

	task automatic check_grant(input bus_req_t req);
		if (data_next) begin
			data_errs_o += differs("bus_o.addr", data_exp.addr, req.addr);
			data_errs_o += differs("bus_o.we", 32'(data_exp.we), 32'(req.we));
			if (data_exp.we) begin
				data_errs_o += differs("bus_o.be", 32'(data_exp.be), 32'(req.be));
				data_errs_o += differs("bus_o.wdata", data_exp.wdata, req.wdata);
				if (data_exp.addr == done_addr_i) begin
					done_o = 1'b1;
				end
			end
			data_next = 1'b0;
		end else begin
			fetch_errs_o += differs("bus_o.addr", pc, req.addr);
			fetch_errs_o += differs("bus_o.we", 32'd0, 32'(req.we));
			execute_at_pc();
		end
	endtask

	//////////////////////////////
	// bus monitor

	// sampled mid cycle, the values the DUT sees at the next rising edge
	always @(negedge clk_i) begin
		if (!rst_ni) begin
			for (int r = 0; r < 32; r++) begin
				regs[r] = '0;
			end
			pc           = `RV32_RESET_PC;
			data_next    = 1'b0;
			enable_seen  = 1'b0;
			outstanding  = 1'b0;
			waiting      = 1'b0;
			done_o       = 1'b0;
			fetch_errs_o = 0;
			data_errs_o  = 0;
			proto_errs_o = 0;
		end else begin
			if (fetch_enable_i) begin
				enable_seen = 1'b1;
			end
			if (bus_req_i && !enable_seen) begin
				$display("bus request at %0t before fetch_enable_i was raised", $time);
				proto_errs_o++;
			end
			if (bus_req_i && outstanding) begin
				$display("new bus request at %0t while a transaction is outstanding", $time);
				proto_errs_o++;
			end
			if (waiting && !bus_req_i) begin
				$display("bus request withdrawn at %0t before its grant", $time);
				proto_errs_o++;
			end else if (waiting && bus_i !== held) begin
				$display("** Error at %0t: bus_o expected %h got %h", $time, held, bus_i);
				proto_errs_o++;
			end
			if (bus_rvalid_i) begin
				if (!outstanding) begin
					$display("rvalid at %0t with no transaction outstanding", $time);
					proto_errs_o++;
				end
				outstanding = 1'b0;
			end
			if (bus_req_i && bus_gnt_i) begin
				check_grant(bus_i);
				outstanding = 1'b1;
				waiting     = 1'b0;
			end else begin
				waiting = bus_req_i;
				held    = bus_i;
			end
		end
	end

endmodule

// ==== tb/rv32_core_tb.sv ====
//////////////////////////////
// rv32 core testbench
// random program, memory responder and checker hookup
//////////////////////////////
`timescale 1ns/100ps
`include "rv32_defs.svh"

module rv32_core_tb;
	import rv32_pkg::*;

	localparam int    PROG_LEN  = 200;
	localparam int    RUN_LIMIT = 20000;
	localparam word_t DATA_BASE = 32'h0000_1000;
	localparam word_t DONE_ADDR = DATA_BASE + 32'h200;

	logic     clk_i;
	logic     rst_ni;
	logic     fetch_enable_i;
	logic     bus_req_o;
	bus_req_t bus_o;
	logic     bus_gnt_i;
	logic     bus_rvalid_i;
	word_t    bus_rdata_i;

	logic run_done;
	int   fetch_errs;
	int   data_errs;
	int   proto_errs;
	int   timeout_errs;
	int   cycles;
	int   txn_cnt;

	// memory words indexed by address bits 13:2
	word_t mem [0:4095];
	int    gnt_delay [0:4095];
	int    rvalid_delay [0:4095];

	rv32_core dut (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.fetch_enable_i (fetch_enable_i),
		.bus_req_o      (bus_req_o),
		.bus_o          (bus_o),
		.bus_gnt_i      (bus_gnt_i),
		.bus_rvalid_i   (bus_rvalid_i),
		.bus_rdata_i    (bus_rdata_i)
	);

	rv32_core_checker core_checker (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.fetch_enable_i (fetch_enable_i),
		.bus_req_i      (bus_req_o),
		.bus_i          (bus_o),
		.bus_gnt_i      (bus_gnt_i),
		.bus_rvalid_i   (bus_rvalid_i),
		.done_addr_i    (DONE_ADDR),
		.done_o         (run_done),
		.fetch_errs_o   (fetch_errs),
		.data_errs_o    (data_errs),
		.proto_errs_o   (proto_errs)
	);

	initial begin
		clk_i = 1'b0;
		forever begin
			#50 clk_i = ~clk_i;
		end
	end

	task automatic step();
		@(posedge clk_i);
		#1;
	endtask

	//////////////////////////////
	// instruction formats

	function automatic word_t u_type(input reg_idx_t rd, input logic [19:0] imm);
		return {imm, rd, `RV32_OPC_LUI};
	endfunction

	function automatic word_t i_type(input logic [6:0] opc, input logic [2:0] f3,
		input reg_idx_t rd, input reg_idx_t rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
		input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
		return {f7, rs2, rs1, f3, rd, `RV32_OPC_OP};
	endfunction

	function automatic word_t s_type(input logic [2:0] f3, input reg_idx_t rs1,
		input reg_idx_t rs2, input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV32_OPC_STORE};
	endfunction

	function automatic word_t b_type(input logic [2:0] f3, input reg_idx_t rs1,
		input reg_idx_t rs2, input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV32_OPC_BRANCH};
	endfunction

	function automatic word_t j_type(input reg_idx_t rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, `RV32_OPC_JAL};
	endfunction

	function automatic word_t fill_word(input word_t addr);
		return (addr * 32'h9e37_79b9) ^ 32'h2545_f491;
	endfunction

	//////////////////////////////
	// program generator

	task automatic build_program();
		int         k;
		int         kind;
		int         skip;
		reg_idx_t   rd;
		reg_idx_t   rs1;
		reg_idx_t   rs2;
		logic [2:0] f3;
		logic [6:0] f7;
		for (k = 0; k < 4096; k++) begin
			mem[k] = fill_word(k * 4);
		end
		mem[0] = u_type(5'd8, DATA_BASE[31:12]);
		for (k = 1; k <= PROG_LEN; k++) begin
			kind = $urandom % 16;
			rd   = 5'd1 + 5'($urandom % 7);
			rs1  = 5'($urandom % 8);
			rs2  = ($urandom % 3 == 0) ? rs1 : 5'($urandom % 8);
			// forward targets never go past the first epilogue word
			skip = 1 + $urandom % 4;
			if (k + skip > PROG_LEN + 1) begin
				skip = PROG_LEN + 1 - k;
			end
			f7 = `RV32_F7_ADD;
			case ($urandom % 5)
				0: f3 = `RV32_F3_ADD;
				1: f3 = `RV32_F3_AND;
				2: f3 = `RV32_F3_OR;
				3: f3 = `RV32_F3_XOR;
				default: begin
					f3 = `RV32_F3_ADD;
					f7 = `RV32_F7_SUB;
				end
			endcase
			case (kind)
				0, 1:    mem[k] = u_type(rd, 20'($urandom));
				2, 3, 4: mem[k] = i_type(`RV32_OPC_OP_IMM, `RV32_F3_ADD, rd, rs1, 12'($urandom));
				5, 6, 7: mem[k] = r_type(f7, f3, rd, rs1, rs2);
				8, 9:    mem[k] = i_type(`RV32_OPC_LOAD, `RV32_F3_LW, rd, 5'd8,
					12'(($urandom % 64) * 4));
				10, 11:  mem[k] = s_type(`RV32_F3_SW, 5'd8, rs2, 12'(($urandom % 64) * 4));
				12:      mem[k] = s_type(`RV32_F3_SB, 5'd8, rs2, 12'($urandom % 256));
				13, 14:  mem[k] = b_type(($urandom % 2) ? `RV32_F3_BEQ : `RV32_F3_BNE,
					rs1, rs2, 13'(skip * 4));
				default: mem[k] = j_type(rd, 21'(skip * 4));
			endcase
		end
		// dump x1..x7, then the done store and a jump to itself
		for (k = 1; k <= 7; k++) begin
			mem[PROG_LEN + k] = s_type(`RV32_F3_SW, 5'd8, 5'(k), 12'(12'h100 + k * 4));
		end
		mem[PROG_LEN + 8] = s_type(`RV32_F3_SW, 5'd8, 5'd1, 12'(DONE_ADDR - DATA_BASE));
		mem[PROG_LEN + 9] = j_type(5'd0, 21'd0);
	endtask

	//////////////////////////////
	// memory responder

	task automatic serve_bus();
		bus_req_t req;
		word_t    rdata;
		int       idx;
		int       b;
		repeat (gnt_delay[txn_cnt % 4096]) step();
		req       = bus_o;
		bus_gnt_i = 1'b1;
		step();
		bus_gnt_i = 1'b0;
		idx       = req.addr[13:2];
		rdata     = mem[idx];
		if (req.we) begin
			for (b = 0; b < 4; b++) begin
				if (req.be[b]) begin
					mem[idx][8*b +: 8] = req.wdata[8*b +: 8];
				end
			end
		end
		repeat (rvalid_delay[txn_cnt % 4096] - 1) step();
		bus_rvalid_i = 1'b1;
		bus_rdata_i  = req.we ? '0 : rdata;
		step();
		bus_rvalid_i = 1'b0;
		txn_cnt++;
	endtask

	initial begin
		bus_gnt_i    = 1'b0;
		bus_rvalid_i = 1'b0;
		bus_rdata_i  = '0;
		txn_cnt      = 0;
		forever begin
			step();
			if (rst_ni && bus_req_o) begin
				serve_bus();
			end
		end
	end

	//////////////////////////////
	// run

	initial begin
		void'($urandom(32'h2fad86d7));
		rst_ni         = 1'b0;
		fetch_enable_i = 1'b0;
		timeout_errs   = 0;
		build_program();
		for (int i = 0; i < 4096; i++) begin
			gnt_delay[i]            = $urandom % 4;
			rvalid_delay[i]         = 1 + $urandom % 3;
			core_checker.ref_mem[i] = mem[i];
		end
		repeat (10) step();
		rst_ni = 1'b1;
		// idle with the core enabled off, no request may appear
		repeat (5) step();
		fetch_enable_i = 1'b1;
		cycles = 0;
		while (!bus_req_o && cycles < 4) begin
			step();
			cycles++;
		end
		if (!bus_req_o) begin
			$display("timeout: no fetch request after fetch_enable_i went high");
			timeout_errs++;
		end
		cycles = 0;
		while (!run_done && cycles < RUN_LIMIT) begin
			step();
			cycles++;
		end
		if (!run_done) begin
			$display("timeout: the program never stored to the done address");
			timeout_errs++;
		end
		repeat (4) step();
		$display("errors: fetch %0d, data %0d, protocol %0d, timeout %0d",
			fetch_errs, data_errs, proto_errs, timeout_errs);
		if (fetch_errs + data_errs + proto_errs + timeout_errs == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// ==== rv32_core.f ====
+incdir+include
logic/rv32_pkg.sv
logic/rv32_regfile.sv
logic/rv32_fetch.sv
logic/rv32_lsu.sv
logic/rv32_bus_arbiter.sv
logic/rv32_decode_exec.sv
logic/rv32_core.sv
tb/rv32_core_checker.sv
tb/rv32_core_tb.sv
